//--- design/memPkg.sv
package memPkg;

   // word geometry
   localparam int DATA_W = 32;
   localparam int ADDR_W = 10;
   localparam int LANES = 4;
   localparam int BYTE_W = DATA_W / LANES;

   // words per lane array
   localparam int DEPTH = 1 << ADDR_W;

   // run length of a fetch, 0 stands for 256 words
   localparam int FETCH_LEN_W = 8;

   // full data word
   typedef logic [DATA_W-1:0] word_t;

   // word address, not byte address
   typedef logic [ADDR_W-1:0] addr_t;

   // bit n enables byte n of the word
   typedef logic [LANES-1:0] strb_t;

   // one lane of a word
   typedef logic [BYTE_W-1:0] byte_t;

   // words left in a fetch run
   typedef logic [FETCH_LEN_W-1:0] fetchLen_t;

   // fetch sequencer states
   typedef enum logic [1:0] {
      IDLE,
      READ,
      PRESENT
   } fetchState_t;

endpackage

//--- design/byteLaneRam.sv
`timescale 1ns/1ps

module byteLaneRam (
   input  logic          clk,

   // data side, read and write
   input  logic          i_enA,
   input  logic          i_weA,
   input  memPkg::addr_t i_addrA,
   input  memPkg::byte_t i_dinA,
   output memPkg::byte_t o_doutA,

   // instruction side, read only
   input  logic          i_enB,
   input  memPkg::addr_t i_addrB,
   output memPkg::byte_t o_doutB
);

   import memPkg::*;

   // contents stay undefined until written
   byte_t mem [DEPTH];

   // port A returns the old byte, then writes when enabled
   always_ff @(posedge clk) begin
      if (i_enA) begin
         o_doutA <= mem[i_addrA];
         if (i_weA) begin
            mem[i_addrA] <= i_dinA;
         end
      end
   end

   // port B sees the old byte on a same-edge write
   always_ff @(posedge clk) begin
      if (i_enB) begin
         o_doutB <= mem[i_addrB];
      end
   end

endmodule

//--- design/wordRam.sv
`timescale 1ns/1ps

module wordRam (
   input  logic          clk,
   input  logic          rst,

   // data port
   input  logic          i_valid,
   input  memPkg::addr_t i_addr,
   input  memPkg::word_t i_wdata,
   input  memPkg::strb_t i_wstrb,
   output memPkg::word_t o_rdata,
   output logic          o_ready,

   // instruction port
   input  logic          i_instrEn,
   input  memPkg::addr_t i_instrAddr,
   output memPkg::word_t o_instrData
);

   import memPkg::*;

   genvar lane;

   // one byte-wide array per strobe bit
   generate
      for (lane = 0; lane < LANES; lane++) begin : gLane
         byteLaneRam uLane (
            .clk     (clk),
            .i_enA   (i_valid),
            .i_weA   (i_wstrb[lane]),
            .i_addrA (i_addr),
            .i_dinA  (i_wdata[lane*BYTE_W +: BYTE_W]),
            .o_doutA (o_rdata[lane*BYTE_W +: BYTE_W]),
            .i_enB   (i_instrEn),
            .i_addrB (i_instrAddr),
            .o_doutB (o_instrData[lane*BYTE_W +: BYTE_W])
         );
      end
   endgenerate

   // reply one cycle after every request, no back-pressure
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_ready <= 1'b0;
      end else begin
         o_ready <= i_valid;
      end
   end

endmodule

//--- design/fetchCounter.sv
`timescale 1ns/1ps

module fetchCounter (
   input  logic              clk,
   input  logic              rst,

   // control from the sequencer
   input  logic              i_load,
   input  logic              i_step,

   // run parameters taken on load
   input  memPkg::addr_t     i_startAddr,
   input  memPkg::fetchLen_t i_len,

   // current word and end of run
   output memPkg::addr_t     o_addr,
   output logic              o_last
);

   import memPkg::*;

   fetchLen_t remaining;

   // address wraps at the top of memory by its own width
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_addr <= '0;
      end else if (i_load) begin
         o_addr <= i_startAddr;
      end else if (i_step) begin
         o_addr <= o_addr + addr_t'(1);
      end
   end

   // a zero length wraps through 255 down to 1, giving 256 words
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remaining <= '0;
      end else if (i_load) begin
         remaining <= i_len;
      end else if (i_step) begin
         remaining <= remaining - fetchLen_t'(1);
      end
   end

   // exactly one word left
   assign o_last = (remaining == fetchLen_t'(1));

endmodule

//--- design/fetchCtrl.sv
`timescale 1ns/1ps

module fetchCtrl (
   input  logic clk,
   input  logic rst,

   // run request and consumer handshake
   input  logic i_fetchStart,
   input  logic i_fetchReady,

   // from the counter
   input  logic i_last,

   // counter and RAM control
   output logic o_load,
   output logic o_step,
   output logic o_instrEn,

   // stream status
   output logic o_fetchValid,
   output logic o_fetchLast,
   output logic o_fetchBusy
);

   import memPkg::*;

   fetchState_t state;
   fetchState_t nextState;
   logic        accept;

   // word taken by the consumer this cycle
   assign accept = o_fetchValid && i_fetchReady;

   always_comb begin
      nextState = state;
      case (state)
         IDLE: begin
            if (i_fetchStart) begin
               nextState = READ;
            end
         end
         READ: begin
            nextState = PRESENT;
         end
         PRESENT: begin
            if (accept) begin
               nextState = i_last ? IDLE : READ;
            end
         end
         default: begin
            nextState = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= nextState;
      end
   end

   // start is only taken while idle
   assign o_load = (state == IDLE) && i_fetchStart;

   // one read per word, data held by the RAM afterwards
   assign o_instrEn = (state == READ);

   // advance only when another word follows
   assign o_step = (state == PRESENT) && accept && !i_last;

   assign o_fetchBusy = (state != IDLE);

   // valid and last held steady until accepted
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_fetchValid <= 1'b0;
         o_fetchLast <= 1'b0;
      end else if (state == READ) begin
         o_fetchValid <= 1'b1;
         o_fetchLast <= i_last;
      end else if (accept) begin
         o_fetchValid <= 1'b0;
         o_fetchLast <= 1'b0;
      end
   end

endmodule

//--- design/memSys.sv
`timescale 1ns/1ps

module memSys (
   input  logic              clk,
   input  logic              rst,

   // data port
   input  logic              i_valid,
   input  memPkg::addr_t     i_addr,
   input  memPkg::word_t     i_wdata,
   input  memPkg::strb_t     i_wstrb,
   output memPkg::word_t     o_rdata,
   output logic              o_ready,

   // fetch request
   input  logic              i_fetchStart,
   input  memPkg::addr_t     i_fetchAddr,
   input  memPkg::fetchLen_t i_fetchLen,

   // fetch stream
   input  logic              i_fetchReady,
   output memPkg::word_t     o_fetchData,
   output logic              o_fetchValid,
   output logic              o_fetchLast,
   output logic              o_fetchBusy
);

   import memPkg::*;

   // sequencer to counter
   logic  load;
   logic  step;
   logic  last;

   // instruction read path
   logic  instrEn;
   addr_t instrAddr;

   wordRam uRam (
      .clk         (clk),
      .rst         (rst),
      .i_valid     (i_valid),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .i_wstrb     (i_wstrb),
      .o_rdata     (o_rdata),
      .o_ready     (o_ready),
      .i_instrEn   (instrEn),
      .i_instrAddr (instrAddr),
      // RAM output doubles as the stream data
      .o_instrData (o_fetchData)
   );

   fetchCounter uCounter (
      .clk         (clk),
      .rst         (rst),
      .i_load      (load),
      .i_step      (step),
      .i_startAddr (i_fetchAddr),
      .i_len       (i_fetchLen),
      .o_addr      (instrAddr),
      .o_last      (last)
   );

   fetchCtrl uCtrl (
      .clk          (clk),
      .rst          (rst),
      .i_fetchStart (i_fetchStart),
      .i_fetchReady (i_fetchReady),
      .i_last       (last),
      .o_load       (load),
      .o_step       (step),
      .o_instrEn    (instrEn),
      .o_fetchValid (o_fetchValid),
      .o_fetchLast  (o_fetchLast),
      .o_fetchBusy  (o_fetchBusy)
   );

endmodule

//--- tests/memSys_assert.sv
`timescale 1ns/1ps

module memSys_assert (
   input  logic          clk,
   input  logic          rst,
   input  logic          i_valid,
   input  logic          o_ready,
   input  logic          i_fetchReady,
   input  memPkg::word_t o_fetchData,
   input  logic          o_fetchValid,
   input  logic          o_fetchLast
);

   import memPkg::*;

   // number of assertion failures so far
   int failCount = 0;

   // data port reply follows every request by one cycle
   readyAfterValid: assert property (@(posedge clk) disable iff (rst)
      i_valid |=> o_ready)
      else begin
         $error("o_ready missing one cycle after i_valid");
         failCount++;
      end

   // no reply without a request
   noSpuriousReady: assert property (@(posedge clk) disable iff (rst)
      !i_valid |=> !o_ready)
      else begin
         $error("o_ready high without a request");
         failCount++;
      end

   // stalled word holds until the consumer takes it
   holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
      (o_fetchValid && !i_fetchReady) |=>
         (o_fetchValid && $stable(o_fetchData) && $stable(o_fetchLast)))
      else begin
         $error("fetch stream changed while stalled");
         failCount++;
      end

   lastOnlyWithValid: assert property (@(posedge clk) disable iff (rst)
      o_fetchLast |-> o_fetchValid)
      else begin
         $error("o_fetchLast high without o_fetchValid");
         failCount++;
      end

endmodule

bind memSys memSys_assert uAssert (
   .clk          (clk),
   .rst          (rst),
   .i_valid      (i_valid),
   .o_ready      (o_ready),
   .i_fetchReady (i_fetchReady),
   .o_fetchData  (o_fetchData),
   .o_fetchValid (o_fetchValid),
   .o_fetchLast  (o_fetchLast)
);

//--- tests/memSysTb.sv
`timescale 1ns/1ps

module memSysTb;

   import memPkg::*;

   localparam int MAX_WAIT = 4000;

   logic      clk;
   logic      rst;
   logic      i_valid;
   addr_t     i_addr;
   word_t     i_wdata;
   strb_t     i_wstrb;
   word_t     o_rdata;
   logic      o_ready;
   logic      i_fetchStart;
   addr_t     i_fetchAddr;
   fetchLen_t i_fetchLen;
   logic      i_fetchReady;
   word_t     o_fetchData;
   logic      o_fetchValid;
   logic      o_fetchLast;
   logic      o_fetchBusy;

   // reference memory, written through byte strobes
   word_t model [DEPTH];

   // words taken from the fetch stream
   word_t received [$];
   logic  lastFlags [$];
   word_t stallFree [$];

   int errors;
   int testStartErrors;
   int testsRun;
   int testsFailed;
   int unsigned rndSeed;

   memSys UUT (
      .clk          (clk),
      .rst          (rst),
      .i_valid      (i_valid),
      .i_addr       (i_addr),
      .i_wdata      (i_wdata),
      .i_wstrb      (i_wstrb),
      .o_rdata      (o_rdata),
      .o_ready      (o_ready),
      .i_fetchStart (i_fetchStart),
      .i_fetchAddr  (i_fetchAddr),
      .i_fetchLen   (i_fetchLen),
      .i_fetchReady (i_fetchReady),
      .o_fetchData  (o_fetchData),
      .o_fetchValid (o_fetchValid),
      .o_fetchLast  (o_fetchLast),
      .o_fetchBusy  (o_fetchBusy)
   );

   always #20 clk = ~clk;

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected) begin
         $display("ERROR at %0t: %s got %h expected %h", $time, name, got, expected);
         errors++;
      end
   endtask

   task automatic beginTest();
      testStartErrors = errors;
      testsRun++;
   endtask

   task automatic endTest(input string name);
      if (errors == testStartErrors) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - testStartErrors);
         testsFailed++;
      end
   endtask

   // byte n of the new word replaces byte n of the old one when strobe bit n is set
   function automatic word_t mergeBytes(input word_t oldWord, input word_t newWord,
                                        input strb_t strb);
      word_t result;
      result = oldWord;
      for (int n = 0; n < LANES; n++) begin
         if (strb[n]) begin
            result[8*n +: 8] = newWord[8*n +: 8];
         end
      end
      return result;
   endfunction

   // called and returns at a falling edge
   task automatic dataRequest(input addr_t addr, input word_t wdata, input strb_t wstrb,
                              output word_t rdata);
      int cycles;
      i_valid = 1'b1;
      i_addr = addr;
      i_wdata = wdata;
      i_wstrb = wstrb;
      @(negedge clk);
      i_valid = 1'b0;
      i_wstrb = '0;
      cycles = 1;
      while (!o_ready && cycles < MAX_WAIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!o_ready) begin
         $display("data port never replied to the request at address %h", addr);
         errors++;
      end
      checkValue("o_ready latency", cycles, 1);
      rdata = o_rdata;
   endtask

   task automatic preloadWords(input addr_t start, input int count);
      addr_t a;
      word_t data;
      word_t rd;
      for (int i = 0; i < count; i++) begin
         a = start + addr_t'(i);
         data = $urandom;
         dataRequest(a, data, 4'hF, rd);
         model[a] = data;
      end
   endtask

   task automatic runFetch(input addr_t start, input fetchLen_t len, input logic randomReady);
      int    expected;
      int    cycles;
      logic  done;
      addr_t a;
      expected = (len == 0) ? 256 : len;
      received.delete();
      lastFlags.delete();
      i_fetchStart = 1'b1;
      i_fetchAddr = start;
      i_fetchLen = len;
      @(negedge clk);
      i_fetchStart = 1'b0;
      checkValue("o_fetchBusy", o_fetchBusy, 1);
      cycles = 0;
      done = 1'b0;
      while (!done && cycles < MAX_WAIT) begin
         i_fetchReady = randomReady ? ($urandom % 3 != 0) : 1'b1;
         // taken at the next rising edge
         if (o_fetchValid && i_fetchReady) begin
            received.push_back(o_fetchData);
            lastFlags.push_back(o_fetchLast);
            if (o_fetchLast) begin
               done = 1'b1;
            end
         end
         @(negedge clk);
         cycles++;
      end
      i_fetchReady = 1'b0;
      if (!done) begin
         $display("fetch run from %h never delivered its last word", start);
         errors++;
      end else begin
         checkValue("o_fetchBusy", o_fetchBusy, 0);
      end
      checkValue("fetch word count", received.size(), expected);
      for (int idx = 0; idx < received.size(); idx++) begin
         a = start + addr_t'(idx);
         checkValue("o_fetchData", received[idx], model[a]);
         checkValue("o_fetchLast", lastFlags[idx], idx == expected - 1);
      end
   endtask

   task automatic testReset();
      beginTest();
      checkValue("o_ready", o_ready, 0);
      checkValue("o_fetchValid", o_fetchValid, 0);
      checkValue("o_fetchLast", o_fetchLast, 0);
      checkValue("o_fetchBusy", o_fetchBusy, 0);
      endTest("reset");
   endtask

   task automatic testFullWords();
      addr_t addrs [16];
      word_t data;
      word_t rd;
      beginTest();
      for (int i = 0; i < 16; i++) begin
         addrs[i] = addr_t'($urandom % DEPTH);
         data = $urandom;
         dataRequest(addrs[i], data, 4'hF, rd);
         model[addrs[i]] = data;
      end
      for (int i = 0; i < 16; i++) begin
         dataRequest(addrs[i], $urandom, 4'h0, rd);
         checkValue("o_rdata", rd, model[addrs[i]]);
      end
      endTest("full word write and read");
   endtask

   task automatic testByteStrobes();
      addr_t a;
      word_t data;
      word_t rd;
      strb_t strb;
      beginTest();
      for (int i = 0; i < 24; i++) begin
         a = addr_t'($urandom % DEPTH);
         data = $urandom;
         dataRequest(a, data, 4'hF, rd);
         model[a] = data;
         strb = strb_t'($urandom);
         data = $urandom;
         // write cycle still returns the word before the write
         dataRequest(a, data, strb, rd);
         checkValue("o_rdata old word", rd, model[a]);
         model[a] = mergeBytes(model[a], data, strb);
         dataRequest(a, 32'h0, 4'h0, rd);
         checkValue("o_rdata merged", rd, model[a]);
      end
      endTest("byte strobes");
   endtask

   task automatic testFetchNoStall();
      beginTest();
      preloadWords(10'd1018, 12);
      runFetch(10'd1018, 8'd12, 1'b0);
      stallFree = received;
      endTest("fetch without stalls");
   endtask

   task automatic testFetchStalled();
      beginTest();
      runFetch(10'd1018, 8'd12, 1'b1);
      checkValue("stalled word count", received.size(), stallFree.size());
      for (int i = 0; i < received.size() && i < stallFree.size(); i++) begin
         checkValue("stalled o_fetchData", received[i], stallFree[i]);
      end
      // zero length runs 256 words across the wrap
      preloadWords(10'd900, 256);
      runFetch(10'd900, 8'd0, 1'b1);
      endTest("fetch with back-pressure");
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      i_valid = 1'b0;
      i_addr = '0;
      i_wdata = '0;
      i_wstrb = '0;
      i_fetchStart = 1'b0;
      i_fetchAddr = '0;
      i_fetchLen = '0;
      i_fetchReady = 1'b0;
      errors = 0;
      testsRun = 0;
      testsFailed = 0;
      rndSeed = 32'h3932bdcd;
      void'($urandom(rndSeed));

      repeat (2) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      testReset();
      testFullWords();
      testByteStrobes();
      testFetchNoStall();
      testFetchStalled();

      if (UUT.uAssert.failCount != 0) begin
         $display("%0d handshake assertions failed during the run", UUT.uAssert.failCount);
         errors += UUT.uAssert.failCount;
      end

      $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- tb.f
design/memPkg.sv
design/byteLaneRam.sv
design/wordRam.sv
design/fetchCounter.sv
design/fetchCtrl.sv
design/memSys.sv
tests/memSys_assert.sv
tests/memSysTb.sv
